//--- hw/fx3_pkg.sv
package fx3_pkg;

    // one slave FIFO data bus word
    typedef logic [31:0] word_t;

    // socket address on the A1 and A0 pins
    typedef logic [1:0] fifo_addr_t;

    // status byte for the board LEDs
    typedef logic [7:0] led_t;

    // controller states, also the mode code seen by gpif_io
    // the encoding order sets the low nibble of the status byte
    typedef enum logic [1:0] {
        MODE_IDLE       = 2'd0,
        MODE_STREAM_OUT = 2'd1,
        MODE_TURNAROUND = 2'd2,
        MODE_STREAM_IN  = 2'd3
    } mode_e;

    // OUT socket, host to FPGA
    localparam fifo_addr_t ADDR_STREAM_OUT = 2'b11;

    // IN socket, FPGA to host
    localparam fifo_addr_t ADDR_STREAM_IN = 2'b00;

    // parked address between transfers
    localparam fifo_addr_t ADDR_IDLE = 2'b10;

endpackage

//--- hw/gpif_io.sv
`timescale 1ns/1ps

module gpif_io (
    input  logic                usb_clk,
    input  logic                reset_,
    input  logic                flaga_i,
    input  logic                flagb_i,
    input  logic                flagc_i,
    input  logic                flagd_i,
    input  fx3_pkg::word_t      data_i,
    input  fx3_pkg::mode_e      mode_i,
    input  logic                rd_req_i,
    input  logic                wr_req_i,
    input  fx3_pkg::word_t      wr_data_i,
    output logic                flaga_q_o,
    output logic                flagb_q_o,
    output logic                flagc_q_o,
    output logic                flagd_q_o,
    output fx3_pkg::word_t      rd_data_o,
    output logic                slcs_n_o,
    output logic                slrd_n_o,
    output logic                sloe_n_o,
    output logic                slwr_n_o,
    output fx3_pkg::fifo_addr_t addr_o,
    output fx3_pkg::word_t      data_o,
    output logic                data_oe_o
);
    import fx3_pkg::*;

    fifo_addr_t addr_d;

    // socket follows the phase, turnaround stays on the OUT socket
    always_comb begin
        case (mode_i)
            MODE_STREAM_OUT, MODE_TURNAROUND: addr_d = ADDR_STREAM_OUT;
            MODE_STREAM_IN:                   addr_d = ADDR_STREAM_IN;
            default:                          addr_d = ADDR_IDLE;
        endcase
    end

    // flags from the FX3, one flop each
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_q_o <= 1'b0;
            flagb_q_o <= 1'b0;
            flagc_q_o <= 1'b0;
            flagd_q_o <= 1'b0;
        end else begin
            flaga_q_o <= flaga_i;
            flagb_q_o <= flagb_i;
            flagc_q_o <= flagc_i;
            flagd_q_o <= flagd_i;
        end
    end

    // control pins, all driven from flops
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_n_o  <= 1'b1;
            slrd_n_o  <= 1'b1;
            sloe_n_o  <= 1'b1;
            slwr_n_o  <= 1'b1;
            data_oe_o <= 1'b0;
            addr_o    <= ADDR_IDLE;
        end else begin
            slcs_n_o  <= (mode_i == MODE_IDLE);
            slrd_n_o  <= ~rd_req_i;
            sloe_n_o  <= ~rd_req_i;
            slwr_n_o  <= ~wr_req_i;
            data_oe_o <= wr_req_i;
            addr_o    <= addr_d;
        end
    end

    // data bus in both directions
    // outgoing word lines up with slwr and the output enable
    always_ff @(posedge usb_clk) begin
        rd_data_o <= data_i;
        data_o    <= wr_data_i;
    end

endmodule

//--- hw/stream_out_reader.sv
`timescale 1ns/1ps

module stream_out_reader #(
    parameter int BURST_WORDS = 16,
    parameter int RD_LATENCY  = 2
) (
    input  logic           usb_clk,
    input  logic           reset_,
    input  logic           start_i,
    input  fx3_pkg::word_t rd_data_i,
    output logic           rd_req_o,
    output logic           push_o,
    output fx3_pkg::word_t push_data_o,
    output logic           done_o
);
    localparam int CNT_W = (BURST_WORDS > 1) ? $clog2(BURST_WORDS) : 1;
    localparam int VLD_W = RD_LATENCY + 2;

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic             last;
    logic [VLD_W-1:0] vld;

    // strobe every cycle while the burst is running
    assign rd_req_o = active;
    assign last     = (cnt == CNT_W'(BURST_WORDS - 1));

    // burst counter
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            active <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= active && last;
            if (active) begin
                if (last) begin
                    active <= 1'b0;
                    cnt    <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (start_i) begin
                active <= 1'b1;
                cnt    <= '0;
            end
        end
    end

    // a word strobed in cycle n comes back out of the input flop in
    // cycle n + RD_LATENCY + 2, output flop and input flop included.
    // the FX3 has the word on data_i at the RD_LATENCY-th edge after
    // it samples slrd low
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            vld <= '0;
        end else begin
            vld <= {vld[VLD_W-2:0], rd_req_o};
        end
    end

    assign push_o      = vld[VLD_W-1];
    assign push_data_o = rd_data_i;

endmodule

//--- hw/loop_buffer.sv
`timescale 1ns/1ps

module loop_buffer #(
    parameter int BURST_WORDS = 16
) (
    input  logic           usb_clk,
    input  logic           reset_,
    input  logic           push_i,
    input  fx3_pkg::word_t push_data_i,
    input  logic           pop_i,
    output fx3_pkg::word_t head_o,
    output logic           empty_o,
    output logic           full_o
);
    import fx3_pkg::*;

    localparam int PTR_W = (BURST_WORDS > 1) ? $clog2(BURST_WORDS) : 1;
    localparam int CNT_W = $clog2(BURST_WORDS + 1);

    word_t            mem [BURST_WORDS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // overflow and underflow are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(BURST_WORDS));

    // head word is visible without a pop
    assign head_o = mem[rd_ptr];

    always_ff @(posedge usb_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(BURST_WORDS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(BURST_WORDS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/stream_in_writer.sv
`timescale 1ns/1ps

module stream_in_writer #(
    parameter int BURST_WORDS = 16
) (
    input  logic           usb_clk,
    input  logic           reset_,
    input  logic           start_i,
    input  logic           flaga_i,
    input  logic           flagb_i,
    input  fx3_pkg::word_t head_i,
    output logic           pop_o,
    output logic           wr_req_o,
    output fx3_pkg::word_t wr_data_o,
    output logic           done_o
);
    localparam int CNT_W = (BURST_WORDS > 1) ? $clog2(BURST_WORDS) : 1;

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic             last;

    // IN socket must be ready and have room
    // flags are already flopped in gpif_io, so a host stall
    // stops the strobes on the pins two edges later
    assign wr_req_o  = active && flaga_i && flagb_i;
    assign pop_o     = wr_req_o;
    assign wr_data_o = head_i;

    assign last = (cnt == CNT_W'(BURST_WORDS - 1));

    // count only cycles that really wrote, a stall simply holds the head
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            active <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= wr_req_o && last;
            if (active) begin
                if (wr_req_o) begin
                    if (last) begin
                        active <= 1'b0;
                        cnt    <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end else if (start_i) begin
                active <= 1'b1;
                cnt    <= '0;
            end
        end
    end

endmodule

//--- hw/fx3_loop_ctrl.sv
`timescale 1ns/1ps

module fx3_loop_ctrl #(
    parameter int IDLE_GAP = 10
) (
    input  logic           usb_clk,
    input  logic           reset_,
    input  logic           flagc_i,
    input  logic           flagd_i,
    input  logic           buf_empty_i,
    input  logic           buf_full_i,
    input  logic           rd_done_i,
    input  logic           wr_done_i,
    output fx3_pkg::mode_e mode_o,
    output logic           rd_start_o,
    output logic           wr_start_o,
    output fx3_pkg::led_t  led_o
);
    import fx3_pkg::*;

    localparam int GAP_W = (IDLE_GAP > 0) ? $clog2(IDLE_GAP + 1) : 1;

    mode_e            state;
    logic [GAP_W-1:0] holdoff;
    logic [3:0]       bursts;
    logic             go;

    // OUT socket has data, buffer drained and the gap has expired
    assign go = flagc_i && flagd_i && buf_empty_i && (holdoff == '0);

    assign mode_o = state;

    // high nibble completed bursts, low nibble the state index
    assign led_o = {bursts, 2'b00, state};

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state      <= MODE_IDLE;
            holdoff    <= '0;
            bursts     <= 4'd0;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
            case (state)
                MODE_IDLE: begin
                    if (go) begin
                        state      <= MODE_STREAM_OUT;
                        rd_start_o <= 1'b1;
                    end else if (holdoff != '0) begin
                        holdoff <= holdoff - 1'b1;
                    end
                end
                MODE_STREAM_OUT: begin
                    if (rd_done_i) begin
                        state <= MODE_TURNAROUND;
                    end
                end
                MODE_TURNAROUND: begin
                    // wait for the read pipeline to land the last word
                    if (buf_full_i) begin
                        state      <= MODE_STREAM_IN;
                        wr_start_o <= 1'b1;
                    end
                end
                MODE_STREAM_IN: begin
                    if (wr_done_i) begin
                        state   <= MODE_IDLE;
                        holdoff <= GAP_W'(IDLE_GAP);
                        bursts  <= bursts + 1'b1;
                    end
                end
                default: begin
                    state <= MODE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/fx3_loopback_top.sv
`timescale 1ns/1ps

module fx3_loopback_top #(
    parameter int BURST_WORDS = 16,
    parameter int RD_LATENCY  = 2,
    parameter int IDLE_GAP    = 10
) (
    input  logic                usb_clk,
    input  logic                reset_,
    input  logic                flaga_i,
    input  logic                flagb_i,
    input  logic                flagc_i,
    input  logic                flagd_i,
    input  fx3_pkg::word_t      data_i,
    output logic                slcs_n_o,
    output logic                slrd_n_o,
    output logic                sloe_n_o,
    output logic                slwr_n_o,
    output fx3_pkg::fifo_addr_t addr_o,
    output fx3_pkg::word_t      data_o,
    output logic                data_oe_o,
    output fx3_pkg::led_t       led_o
);
    import fx3_pkg::*;

    mode_e mode;
    logic  flaga_q;
    logic  flagb_q;
    logic  flagc_q;
    logic  flagd_q;
    word_t rd_data;
    logic  rd_req;
    logic  rd_start;
    logic  rd_done;
    logic  push;
    word_t push_data;
    logic  pop;
    word_t head;
    logic  buf_empty;
    logic  buf_full;
    logic  wr_req;
    word_t wr_data;
    logic  wr_start;
    logic  wr_done;

    gpif_io io0 (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flaga_i   (flaga_i),
        .flagb_i   (flagb_i),
        .flagc_i   (flagc_i),
        .flagd_i   (flagd_i),
        .data_i    (data_i),
        .mode_i    (mode),
        .rd_req_i  (rd_req),
        .wr_req_i  (wr_req),
        .wr_data_i (wr_data),
        .flaga_q_o (flaga_q),
        .flagb_q_o (flagb_q),
        .flagc_q_o (flagc_q),
        .flagd_q_o (flagd_q),
        .rd_data_o (rd_data),
        .slcs_n_o  (slcs_n_o),
        .slrd_n_o  (slrd_n_o),
        .sloe_n_o  (sloe_n_o),
        .slwr_n_o  (slwr_n_o),
        .addr_o    (addr_o),
        .data_o    (data_o),
        .data_oe_o (data_oe_o)
    );

    fx3_loop_ctrl #(
        .IDLE_GAP (IDLE_GAP)
    ) ctrl0 (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flagc_i     (flagc_q),
        .flagd_i     (flagd_q),
        .buf_empty_i (buf_empty),
        .buf_full_i  (buf_full),
        .rd_done_i   (rd_done),
        .wr_done_i   (wr_done),
        .mode_o      (mode),
        .rd_start_o  (rd_start),
        .wr_start_o  (wr_start),
        .led_o       (led_o)
    );

    stream_out_reader #(
        .BURST_WORDS (BURST_WORDS),
        .RD_LATENCY  (RD_LATENCY)
    ) rd0 (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .start_i     (rd_start),
        .rd_data_i   (rd_data),
        .rd_req_o    (rd_req),
        .push_o      (push),
        .push_data_o (push_data),
        .done_o      (rd_done)
    );

    loop_buffer #(
        .BURST_WORDS (BURST_WORDS)
    ) buf0 (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (buf_empty),
        .full_o      (buf_full)
    );

    stream_in_writer #(
        .BURST_WORDS (BURST_WORDS)
    ) wr0 (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .start_i   (wr_start),
        .flaga_i   (flaga_q),
        .flagb_i   (flagb_q),
        .head_i    (head),
        .pop_o     (pop),
        .wr_req_o  (wr_req),
        .wr_data_o (wr_data),
        .done_o    (wr_done)
    );

endmodule

//--- test/fx3_loopback_props.sv
`timescale 1ns/1ps

module fx3_loopback_props (
    input logic usb_clk,
    input logic reset_,
    input logic slcs_n_o,
    input logic slrd_n_o,
    input logic sloe_n_o,
    input logic slwr_n_o,
    input logic data_oe_o
);

    // read and write never share a cycle on the bus
    no_rd_wr_overlap: assert property (@(posedge usb_clk) disable iff (!reset_)
        !(!slrd_n_o && !slwr_n_o))
        else $error("slrd_n_o and slwr_n_o are low in the same cycle");

    // FPGA drives the bus only while it strobes a write
    oe_follows_wr: assert property (@(posedge usb_clk) disable iff (!reset_)
        data_oe_o == !slwr_n_o)
        else $error("data_oe_o does not match slwr_n_o");

    // any strobe needs chip select
    cs_on_strobe: assert property (@(posedge usb_clk) disable iff (!reset_)
        (!slrd_n_o || !sloe_n_o || !slwr_n_o) |-> !slcs_n_o)
        else $error("strobe low while slcs_n_o is high");

endmodule

bind fx3_loopback_top fx3_loopback_props props0 (
    .usb_clk   (usb_clk),
    .reset_    (reset_),
    .slcs_n_o  (slcs_n_o),
    .slrd_n_o  (slrd_n_o),
    .sloe_n_o  (sloe_n_o),
    .slwr_n_o  (slwr_n_o),
    .data_oe_o (data_oe_o)
);

//--- test/tb_fx3_loopback.sv
`timescale 1ns/1ps

module tb_fx3_loopback;
    import fx3_pkg::*;

    // must match the DUT defaults
    localparam int BURST_WORDS = 16;
    localparam int RD_LATENCY  = 2;
    localparam int IDLE_GAP    = 10;
    localparam int WAIT_LIMIT  = 400;

    logic       usb_clk;
    logic       reset_;
    logic       flaga_i;
    logic       flagb_i;
    logic       flagc_i;
    logic       flagd_i;
    word_t      data_i;
    logic       slcs_n_o;
    logic       slrd_n_o;
    logic       sloe_n_o;
    logic       slwr_n_o;
    fifo_addr_t addr_o;
    word_t      data_o;
    logic       data_oe_o;
    led_t       led_o;

    integer              seed;
    int                  errors;
    int                  cyc;
    int                  bursts;
    logic [RD_LATENCY:0] rd_pipe;
    word_t               out_q[$];
    word_t               exp_q[$];
    word_t               in_q[$];
    int                  rd_cyc_q[$];
    int                  wr_cyc_q[$];

    fx3_loopback_top dut0 (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flaga_i   (flaga_i),
        .flagb_i   (flagb_i),
        .flagc_i   (flagc_i),
        .flagd_i   (flagd_i),
        .data_i    (data_i),
        .slcs_n_o  (slcs_n_o),
        .slrd_n_o  (slrd_n_o),
        .sloe_n_o  (sloe_n_o),
        .slwr_n_o  (slwr_n_o),
        .addr_o    (addr_o),
        .data_o    (data_o),
        .data_oe_o (data_oe_o),
        .led_o     (led_o)
    );

    always #20 usb_clk = ~usb_clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // FX3 model samples the pins at the falling edge where they are stable
    // a low slrd seen here is the one the FX3 takes at the next rising edge
    always @(negedge usb_clk) begin
        cyc = cyc + 1;
        rd_pipe = {rd_pipe[RD_LATENCY-1:0], !slrd_n_o};
        // output enable goes low together with the read strobe
        if (!slrd_n_o) begin
            rd_cyc_q.push_back(cyc);
            check("addr_o", addr_o, ADDR_STREAM_OUT);
            check("sloe_n_o", sloe_n_o, 1'b0);
        end else begin
            check("sloe_n_o", sloe_n_o, 1'b1);
        end
        // word must sit on data_i at the RD_LATENCY-th edge after the sample
        if (rd_pipe[RD_LATENCY]) begin
            if (out_q.size() == 0) begin
                $display("read strobe arrived with no word left in the OUT queue");
                errors++;
                data_i = 32'hdead_beef;
            end else begin
                data_i = out_q.pop_front();
            end
        end else begin
            data_i = 32'hdead_beef;
        end
        if (!slwr_n_o) begin
            wr_cyc_q.push_back(cyc);
            in_q.push_back(data_o);
            check("addr_o", addr_o, ADDR_STREAM_IN);
        end
    end

    task automatic clear_logs();
        out_q.delete();
        exp_q.delete();
        in_q.delete();
        rd_cyc_q.delete();
        wr_cyc_q.delete();
    endtask

    task automatic fill_out_queue(input int n);
        word_t w;
        repeat (n) begin
            w = $random(seed);
            out_q.push_back(w);
            exp_q.push_back(w);
        end
    endtask

    task automatic wait_reads(input int n, output bit ok);
        ok = 0;
        for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
            @(negedge usb_clk);
            ok = (rd_cyc_q.size() >= n);
        end
        if (!ok) begin
            $display("timed out waiting for %0d read strobes", n);
            errors++;
        end
    endtask

    task automatic wait_written(input int n, input bit need_idle, output bit ok);
        ok = 0;
        for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
            @(negedge usb_clk);
            ok = (in_q.size() >= n) && (!need_idle || led_o[3:0] == 4'(MODE_IDLE));
        end
        if (!ok) begin
            $display("timed out waiting for %0d written words", n);
            errors++;
        end
    endtask

    task automatic compare_words();
        check("IN word count", in_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < in_q.size(); i++) begin
            check("data_o", in_q[i], exp_q[i]);
        end
    endtask

    task automatic reset_test();
        @(negedge usb_clk);
        check("slcs_n_o", slcs_n_o, 1'b1);
        check("slrd_n_o", slrd_n_o, 1'b1);
        check("sloe_n_o", sloe_n_o, 1'b1);
        check("slwr_n_o", slwr_n_o, 1'b1);
        check("data_oe_o", data_oe_o, 1'b0);
        check("addr_o", addr_o, ADDR_IDLE);
        check("led_o", led_o, 8'h00);
    endtask

    task automatic idle_hold_test();
        // one of the two OUT flags low at a time
        for (int k = 0; k < 2; k++) begin
            flagc_i = (k == 1);
            flagd_i = (k == 0);
            repeat (50) begin
                @(negedge usb_clk);
                check("slcs_n_o", slcs_n_o, 1'b1);
                check("slrd_n_o", slrd_n_o, 1'b1);
            end
        end
        flagc_i = 1'b0;
        flagd_i = 1'b0;
    endtask

    task automatic single_burst_test(input bit stall);
        bit ok;
        clear_logs();
        fill_out_queue(BURST_WORDS);
        flagc_i = 1'b1;
        flagd_i = 1'b1;
        wait_reads(1, ok);
        if (!ok) return;
        // keep the next burst from starting
        flagc_i = 1'b0;
        if (stall) begin
            wait_written(4, 1'b0, ok);
            if (!ok) return;
            flagb_i = 1'b0;
            for (int i = 0; i < 20; i++) begin
                @(negedge usb_clk);
                // flag passes two flops before the strobe reacts
                if (i >= 1) begin
                    check("slwr_n_o", slwr_n_o, 1'b1);
                end
            end
            flagb_i = 1'b1;
        end
        wait_written(BURST_WORDS, 1'b1, ok);
        if (!ok) return;
        bursts++;
        check("read strobe count", rd_cyc_q.size(), BURST_WORDS);
        if (rd_cyc_q.size() == BURST_WORDS) begin
            check("read strobe span", rd_cyc_q[BURST_WORDS-1] - rd_cyc_q[0], BURST_WORDS - 1);
        end
        compare_words();
        check("led_o", led_o, {bursts[3:0], 4'(MODE_IDLE)});
    endtask

    task automatic back_to_back_test();
        bit ok;
        clear_logs();
        fill_out_queue(2 * BURST_WORDS);
        flagc_i = 1'b1;
        flagd_i = 1'b1;
        wait_reads(BURST_WORDS + 1, ok);
        if (!ok) return;
        flagc_i = 1'b0;
        wait_written(2 * BURST_WORDS, 1'b1, ok);
        if (!ok) return;
        bursts += 2;
        check("read strobe count", rd_cyc_q.size(), 2 * BURST_WORDS);
        if (rd_cyc_q.size() > BURST_WORDS && wr_cyc_q.size() >= BURST_WORDS) begin
            if (rd_cyc_q[BURST_WORDS] - wr_cyc_q[BURST_WORDS-1] <= IDLE_GAP) begin
                $display("second burst read started inside the idle holdoff");
                errors++;
            end
        end
        compare_words();
        check("led_o", led_o, {bursts[3:0], 4'(MODE_IDLE)});
    endtask

    initial begin
        seed    = 32'hda4a_994e;
        errors  = 0;
        cyc     = 0;
        bursts  = 0;
        rd_pipe = '0;
        usb_clk = 1'b0;
        reset_  = 1'b0;
        flaga_i = 1'b1;
        flagb_i = 1'b1;
        flagc_i = 1'b0;
        flagd_i = 1'b0;
        data_i  = '0;
        repeat (8) @(negedge usb_clk);
        reset_ = 1'b1;

        reset_test();
        idle_hold_test();
        single_burst_test(1'b0);
        single_burst_test(1'b1);
        back_to_back_test();

        $display("all tests done, error count %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- files.f
hw/fx3_pkg.sv
hw/gpif_io.sv
hw/stream_out_reader.sv
hw/loop_buffer.sv
hw/stream_in_writer.sv
hw/fx3_loop_ctrl.sv
hw/fx3_loopback_top.sv
test/fx3_loopback_props.sv
test/tb_fx3_loopback.sv
